/* Makefile */
TOP  = tb_ex_stage
SRCS = $(shell cat ex_stage.f)

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): ex_stage.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ex_stage.f -o V$(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/ex_alu.sv */
// integer alu
module ex_alu
  import ex_width_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic [ALU_OP_WD-1:0] i_alu_op,
  input  logic [WORD_WD-1:0]   i_src1,
  input  logic [WORD_WD-1:0]   i_src2,
  input  logic                 i_word_cut,
  output logic [WORD_WD-1:0]   o_result
);

  logic [5:0]         shamt;
  logic [WORD_WD-1:0] srl_src;
  logic [WORD_WD-1:0] sra_src;
  logic [WORD_WD-1:0] raw;

  // word forms shift by five bits only
  assign shamt = i_word_cut ? {1'b0, i_src2[4:0]} : i_src2[5:0];

  // word right shifts see only the low half
  always_comb begin
    if (i_word_cut) begin
      srl_src = {32'b0, i_src1[31:0]};
      sra_src = {{32{i_src1[31]}}, i_src1[31:0]};
    end else begin
      srl_src = i_src1;
      sra_src = i_src1;
    end
  end

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   raw = i_src1 + i_src2;
      ALU_SUB:   raw = i_src1 - i_src2;
      ALU_SLL:   raw = i_src1 << shamt;
      ALU_SLT:   raw = {63'b0, $signed(i_src1) < $signed(i_src2)};
      ALU_SLTU:  raw = {63'b0, i_src1 < i_src2};
      ALU_XOR:   raw = i_src1 ^ i_src2;
      ALU_SRL:   raw = srl_src >> shamt;
      ALU_SRA:   raw = $unsigned($signed(sra_src) >>> shamt);
      ALU_OR:    raw = i_src1 | i_src2;
      ALU_AND:   raw = i_src1 & i_src2;
      ALU_PASS2: raw = i_src2;
      default:   raw = '0;
    endcase
  end

  // *w instructions return a sign-extended 32-bit result
  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  // only the rv64 word ops exist in a cut form
  always_comb begin
    assert final (!i_word_cut ||
                  (i_alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA}))
      else $error("word cut with alu op %0d", i_alu_op);
  end

endmodule

/* design/ex_ctrl_pkg.sv */
// execute stage control encodings
package ex_ctrl_pkg;

  // alu operation
  localparam int ALU_OP_WD = 5;

  localparam logic [ALU_OP_WD-1:0] ALU_ADD   = 5'd0;
  localparam logic [ALU_OP_WD-1:0] ALU_SUB   = 5'd1;
  localparam logic [ALU_OP_WD-1:0] ALU_SLL   = 5'd2;
  localparam logic [ALU_OP_WD-1:0] ALU_SLT   = 5'd3;
  localparam logic [ALU_OP_WD-1:0] ALU_SLTU  = 5'd4;
  localparam logic [ALU_OP_WD-1:0] ALU_XOR   = 5'd5;
  localparam logic [ALU_OP_WD-1:0] ALU_SRL   = 5'd6;
  localparam logic [ALU_OP_WD-1:0] ALU_SRA   = 5'd7;
  localparam logic [ALU_OP_WD-1:0] ALU_OR    = 5'd8;
  localparam logic [ALU_OP_WD-1:0] ALU_AND   = 5'd9;
  localparam logic [ALU_OP_WD-1:0] ALU_PASS2 = 5'd10; // lui

  // operand 1 select
  localparam logic SRC1_RS1 = 1'b0;
  localparam logic SRC1_PC  = 1'b1;

  // operand 2 select
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // link address for jal/jalr

  // memory access size and sign
  localparam int MEM_OP_WD = 3;

  localparam logic [MEM_OP_WD-1:0] MEM_B  = 3'd0;
  localparam logic [MEM_OP_WD-1:0] MEM_BU = 3'd1;
  localparam logic [MEM_OP_WD-1:0] MEM_H  = 3'd2;
  localparam logic [MEM_OP_WD-1:0] MEM_HU = 3'd3;
  localparam logic [MEM_OP_WD-1:0] MEM_W  = 3'd4;
  localparam logic [MEM_OP_WD-1:0] MEM_WU = 3'd5;
  localparam logic [MEM_OP_WD-1:0] MEM_D  = 3'd6;

  // csr read-modify-write operation
  localparam int CSR_OP_WD = 3;

  localparam logic [CSR_OP_WD-1:0] CSR_NONE = 3'd0;
  localparam logic [CSR_OP_WD-1:0] CSR_RW   = 3'd1;
  localparam logic [CSR_OP_WD-1:0] CSR_RS   = 3'd2;
  localparam logic [CSR_OP_WD-1:0] CSR_RC   = 3'd3;
  localparam logic [CSR_OP_WD-1:0] CSR_RWI  = 3'd4;
  localparam logic [CSR_OP_WD-1:0] CSR_RSI  = 3'd5;
  localparam logic [CSR_OP_WD-1:0] CSR_RCI  = 3'd6;

endpackage

/* design/ex_exu.sv */
// execute unit
module ex_exu
  import ex_width_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic [WORD_WD-1:0]   i_rs1data,
  input  logic [WORD_WD-1:0]   i_rs2data,
  input  logic [WORD_WD-1:0]   i_imm,
  input  logic [WORD_WD-1:0]   i_pc,
  input  logic [WORD_WD-1:0]   i_csrrdata,
  input  logic                 i_alu_src1_sel,
  input  logic [1:0]           i_alu_src2_sel,
  input  logic [ALU_OP_WD-1:0] i_alu_op,
  input  logic                 i_alu_word_cut_sel,
  input  logic [CSR_OP_WD-1:0] i_csr_op,
  output logic [WORD_WD-1:0]   o_alu_result,
  output logic [WORD_WD-1:0]   o_csr_result
);

  logic [WORD_WD-1:0] alu_src1;
  logic [WORD_WD-1:0] alu_src2;

  assign alu_src1 = (i_alu_src1_sel == SRC1_PC) ? i_pc : i_rs1data; // auipc, jal

  always_comb begin
    case (i_alu_src2_sel)
      SRC2_RS2:  alu_src2 = i_rs2data;
      SRC2_IMM:  alu_src2 = i_imm;
      SRC2_FOUR: alu_src2 = WORD_WD'(4);
      default:   alu_src2 = '0;
    endcase
  end

  ex_alu u_alu (
    .i_alu_op   (i_alu_op),
    .i_src1     (alu_src1),
    .i_src2     (alu_src2),
    .i_word_cut (i_alu_word_cut_sel),
    .o_result   (o_alu_result)
  );

  // new csr value, old value comes from decode
  always_comb begin
    case (i_csr_op)
      CSR_RW:  o_csr_result = i_rs1data;
      CSR_RS:  o_csr_result = i_csrrdata | i_rs1data;
      CSR_RC:  o_csr_result = i_csrrdata & ~i_rs1data;
      CSR_RWI: o_csr_result = i_imm; // zimm already extended
      CSR_RSI: o_csr_result = i_csrrdata | i_imm;
      CSR_RCI: o_csr_result = i_csrrdata & ~i_imm;
      default: o_csr_result = '0;
    endcase
  end

endmodule

/* design/ex_lsu_store.sv */
// store size, strobe and data alignment
module ex_lsu_store
  import ex_width_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic [MEM_OP_WD-1:0]     i_mem_op,
  input  logic [2:0]               i_addr_low,
  input  logic [WORD_WD-1:0]       i_wdata,
  output logic [1:0]               o_size,
  output logic [SRAM_WMASK_WD-1:0] o_wmask,
  output logic [SRAM_DATA_WD-1:0]  o_wdata
);

  logic [SRAM_WMASK_WD-1:0] base_mask;

  always_comb begin
    case (i_mem_op)
      MEM_B, MEM_BU: begin
        o_size    = 2'd0;
        base_mask = 8'h01;
      end
      MEM_H, MEM_HU: begin
        o_size    = 2'd1;
        base_mask = 8'h03;
      end
      MEM_W, MEM_WU: begin
        o_size    = 2'd2;
        base_mask = 8'h0f;
      end
      MEM_D: begin
        o_size    = 2'd3;
        base_mask = 8'hff;
      end
      default: begin
        o_size    = 2'd0;
        base_mask = '0;
      end
    endcase
  end

  // move strobes and bytes into the addressed lanes
  assign o_wmask = base_mask << i_addr_low;
  assign o_wdata = i_wdata << {i_addr_low, 3'b000};

endmodule

/* design/ex_stage.sv */
// execute stage
module ex_stage
  import ex_width_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  // from decode
  input  logic                     i_ds_to_es_valid,
  output logic                     o_es_allowin,
  input  logic [WORD_WD-1:0]       i_ds_rs1data,
  input  logic [WORD_WD-1:0]       i_ds_rs2data,
  input  logic [WORD_WD-1:0]       i_ds_csrrdata,
  input  logic [WORD_WD-1:0]       i_ds_imm,
  input  logic [WORD_WD-1:0]       i_ds_pc,
  input  logic [GPR_ADDR_WD-1:0]   i_ds_rd,
  input  logic [CSR_ADDR_WD-1:0]   i_ds_csr,
  input  logic                     i_ds_alu_src1_sel,
  input  logic [1:0]               i_ds_alu_src2_sel,
  input  logic                     i_ds_alu_word_cut_sel,
  input  logic [ALU_OP_WD-1:0]     i_ds_alu_op,
  input  logic                     i_ds_gpr_wen,
  input  logic                     i_ds_csr_wen,
  input  logic                     i_ds_mem_ren,
  input  logic                     i_ds_mem_wen,
  input  logic [MEM_OP_WD-1:0]     i_ds_mem_op,
  input  logic                     i_ds_csr_inst_sel,
  input  logic [CSR_OP_WD-1:0]     i_ds_csr_op,
  input  logic                     i_ds_load_sel,
  // to memory stage
  input  logic                     i_ms_allowin,
  output logic                     o_es_to_ms_valid,
  output logic [GPR_ADDR_WD-1:0]   o_es_rd,
  output logic [CSR_ADDR_WD-1:0]   o_es_csr,
  output logic                     o_es_gpr_wen,
  output logic                     o_es_csr_wen,
  output logic                     o_es_mem_ren,
  output logic                     o_es_mem_wen,
  output logic [MEM_OP_WD-1:0]     o_es_mem_op,
  output logic                     o_es_csr_inst_sel,
  output logic [WORD_WD-1:0]       o_es_csrrdata,
  output logic [WORD_WD-1:0]       o_es_alu_result,
  output logic [WORD_WD-1:0]       o_es_csr_result,
  // back to decode
  output logic                     o_load_sel,
  output logic [GPR_ADDR_WD-1:0]   o_bypass_rd,
  output logic [WORD_WD-1:0]       o_bypass_gpr_data,
  output logic [CSR_ADDR_WD-1:0]   o_bypass_csr,
  output logic [WORD_WD-1:0]       o_bypass_csr_data,
  // data sram
  output logic                     o_data_sram_req,
  output logic                     o_data_sram_op,   // 1 write, 0 read
  output logic [1:0]               o_data_sram_size,
  output logic [SRAM_ADDR_WD-1:0]  o_data_sram_addr,
  output logic [SRAM_WMASK_WD-1:0] o_data_sram_wstrb,
  output logic [SRAM_DATA_WD-1:0]  o_data_sram_wdata,
  input  logic                     i_data_sram_addr_ok
);

  logic                   es_valid;
  logic                   es_ready_go;
  logic                   ds_fire;
  logic                   req_fire;
  logic                   data_sram_ren;
  logic                   data_sram_wen;

  logic [WORD_WD-1:0]     es_rs1data;
  logic [WORD_WD-1:0]     es_rs2data;
  logic [WORD_WD-1:0]     es_csrrdata;
  logic [WORD_WD-1:0]     es_imm;
  logic [WORD_WD-1:0]     es_pc;
  logic [GPR_ADDR_WD-1:0] es_rd;
  logic [CSR_ADDR_WD-1:0] es_csr;
  logic                   es_alu_src1_sel;
  logic [1:0]             es_alu_src2_sel;
  logic                   es_alu_word_cut_sel;
  logic [ALU_OP_WD-1:0]   es_alu_op;
  logic                   es_gpr_wen;
  logic                   es_csr_wen;
  logic                   es_mem_ren;
  logic                   es_mem_wen;
  logic [MEM_OP_WD-1:0]   es_mem_op;
  logic                   es_csr_inst_sel;
  logic [CSR_OP_WD-1:0]   es_csr_op;
  logic                   es_load_sel;

  logic [WORD_WD-1:0]     es_alu_result;
  logic [WORD_WD-1:0]     es_csr_result;

  // handshake
  assign ds_fire          = i_ds_to_es_valid && o_es_allowin;
  assign es_ready_go      = (es_mem_ren || es_mem_wen) ? req_fire : 1'b1; // wait for addr_ok
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  // control fields
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      es_alu_src1_sel     <= SRC1_RS1;
      es_alu_src2_sel     <= SRC2_RS2;
      es_alu_word_cut_sel <= 1'b0;
      es_alu_op           <= ALU_ADD;
      es_gpr_wen          <= 1'b0;
      es_csr_wen          <= 1'b0;
      es_mem_ren          <= 1'b0;
      es_mem_wen          <= 1'b0;
      es_mem_op           <= MEM_B;
      es_csr_inst_sel     <= 1'b0;
      es_csr_op           <= CSR_NONE;
      es_load_sel         <= 1'b0;
    end else if (ds_fire) begin
      es_alu_src1_sel     <= i_ds_alu_src1_sel;
      es_alu_src2_sel     <= i_ds_alu_src2_sel;
      es_alu_word_cut_sel <= i_ds_alu_word_cut_sel;
      es_alu_op           <= i_ds_alu_op;
      es_gpr_wen          <= i_ds_gpr_wen;
      es_csr_wen          <= i_ds_csr_wen;
      es_mem_ren          <= i_ds_mem_ren;
      es_mem_wen          <= i_ds_mem_wen;
      es_mem_op           <= i_ds_mem_op;
      es_csr_inst_sel     <= i_ds_csr_inst_sel;
      es_csr_op           <= i_ds_csr_op;
      es_load_sel         <= i_ds_load_sel;
    end
  end

  // operands and destinations
  always_ff @(posedge i_clk) begin
    if (ds_fire) begin
      es_rs1data  <= i_ds_rs1data;
      es_rs2data  <= i_ds_rs2data;
      es_csrrdata <= i_ds_csrrdata;
      es_imm      <= i_ds_imm;
      es_pc       <= i_ds_pc;
      es_rd       <= i_ds_rd;
      es_csr      <= i_ds_csr;
    end
  end

  ex_exu u_exu (
    .i_rs1data          (es_rs1data),
    .i_rs2data          (es_rs2data),
    .i_imm              (es_imm),
    .i_pc               (es_pc),
    .i_csrrdata         (es_csrrdata),
    .i_alu_src1_sel     (es_alu_src1_sel),
    .i_alu_src2_sel     (es_alu_src2_sel),
    .i_alu_op           (es_alu_op),
    .i_alu_word_cut_sel (es_alu_word_cut_sel),
    .i_csr_op           (es_csr_op),
    .o_alu_result       (es_alu_result),
    .o_csr_result       (es_csr_result)
  );

  // loads only ask when the memory stage can take the data
  assign data_sram_ren    = es_valid && es_mem_ren && i_ms_allowin;
  assign data_sram_wen    = es_valid && es_mem_wen;
  assign o_data_sram_req  = data_sram_ren || data_sram_wen;
  assign o_data_sram_op   = data_sram_wen;
  assign o_data_sram_addr = es_alu_result[SRAM_ADDR_WD-1:0]; // rs1 + imm
  assign req_fire         = o_data_sram_req && i_data_sram_addr_ok;

  ex_lsu_store u_lsu_store (
    .i_mem_op   (es_mem_op),
    .i_addr_low (es_alu_result[2:0]),
    .i_wdata    (es_rs2data),
    .o_size     (o_data_sram_size),
    .o_wmask    (o_data_sram_wstrb),
    .o_wdata    (o_data_sram_wdata)
  );

  assign o_es_rd           = es_rd;
  assign o_es_csr          = es_csr;
  assign o_es_gpr_wen      = es_gpr_wen;
  assign o_es_csr_wen      = es_csr_wen;
  assign o_es_mem_ren      = es_mem_ren;
  assign o_es_mem_wen      = es_mem_wen;
  assign o_es_mem_op       = es_mem_op;
  assign o_es_csr_inst_sel = es_csr_inst_sel;
  assign o_es_csrrdata     = es_csrrdata;
  assign o_es_alu_result   = es_alu_result;
  assign o_es_csr_result   = es_csr_result;

  assign o_load_sel = es_valid && es_load_sel; // decode stalls on a load-use

  // pending results for forwarding
  assign o_bypass_rd       = (es_valid && !es_mem_wen && es_gpr_wen) ? es_rd : '0;
  assign o_bypass_gpr_data = (es_valid && !es_mem_wen && es_gpr_wen) ? es_alu_result : '0;
  assign o_bypass_csr      = (es_valid && !es_mem_wen && es_csr_wen) ? es_csr : '0;
  assign o_bypass_csr_data = (es_valid && !es_mem_wen && es_csr_wen) ? es_csr_result : '0;

  // a stalled request keeps its payload and a store keeps asking
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_sram_req && !i_data_sram_addr_ok |=>
      $stable(o_data_sram_addr) && $stable(o_data_sram_op) &&
      $stable(o_data_sram_wdata) && (o_data_sram_req || !o_data_sram_op))
    else $error("data sram request changed before addr_ok");

  a_store_strb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_data_sram_req && o_data_sram_op |-> (o_data_sram_wstrb != '0))
    else $error("store request with empty strobe");

  // memory instructions leave only on their fire
  a_out_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_es_to_ms_valid |-> es_valid && (!(es_mem_ren || es_mem_wen) || req_fire))
    else $error("es_to_ms_valid without a ready instruction");

endmodule

/* design/ex_width_pkg.sv */
// execute stage widths
package ex_width_pkg;

  // datapath word, shared by gpr, csr, immediate and pc
  localparam int WORD_WD       = 64;

  // register file index
  localparam int GPR_ADDR_WD   = 5;

  // csr index
  localparam int CSR_ADDR_WD   = 12;

  // data sram port
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_DATA_WD  = 64;
  localparam int SRAM_WMASK_WD = 8;  // one strobe per byte

endpackage

/* ex_stage.f */
design/ex_width_pkg.sv
design/ex_ctrl_pkg.sv
design/ex_alu.sv
design/ex_exu.sv
design/ex_lsu_store.sv
design/ex_stage.sv
test/tb_clkgen.sv
test/tb_ex_stage.sv

/* test/tb_clkgen.sv */
// testbench clock and reset
module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // two cycles of reset
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

/* test/tb_ex_stage.sv */
// execute stage testbench
module tb_ex_stage
  import ex_width_pkg::*;
  import ex_ctrl_pkg::*;
();

  localparam int TIMEOUT = 200;

  typedef struct packed {
    logic [WORD_WD-1:0]     rs1, rs2, csrr, imm, pc;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   src1_sel;
    logic [1:0]             src2_sel;
    logic                   wcut;
    logic [ALU_OP_WD-1:0]   alu_op;
    logic                   gpr_wen, csr_wen, ren, wen;
    logic [MEM_OP_WD-1:0]   mem_op;
    logic                   csr_inst;
    logic [CSR_OP_WD-1:0]   csr_op;
    logic                   load;
  } instr_t;

  typedef struct packed {
    logic [WORD_WD-1:0]       alu, csr_res;
    logic [1:0]               size;
    logic [SRAM_WMASK_WD-1:0] strb;
    logic [SRAM_DATA_WD-1:0]  wdata;
  } exp_t;

  logic clk, rst_n;
  logic ds_valid, ms_allowin, addr_ok;
  instr_t ds;
  instr_t in_q[$];
  exp_t exp_q[$];
  logic [15:0] lfsr = 16'd61766;

  logic es_allowin, es_to_ms_valid, es_gpr_wen, es_csr_wen, es_mem_ren, es_mem_wen;
  logic es_csr_inst_sel, load_sel, sram_req, sram_op;
  logic [GPR_ADDR_WD-1:0] es_rd, byp_rd;
  logic [CSR_ADDR_WD-1:0] es_csr, byp_csr;
  logic [MEM_OP_WD-1:0] es_mem_op;
  logic [WORD_WD-1:0] es_csrrdata, es_alu_result, es_csr_result, byp_gpr_data, byp_csr_data;
  logic [1:0] sram_size;
  logic [SRAM_ADDR_WD-1:0] sram_addr;
  logic [SRAM_WMASK_WD-1:0] sram_wstrb;
  logic [SRAM_DATA_WD-1:0] sram_wdata;

  tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

  ex_stage dut (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_ds_to_es_valid(ds_valid), .o_es_allowin(es_allowin),
    .i_ds_rs1data(ds.rs1), .i_ds_rs2data(ds.rs2), .i_ds_csrrdata(ds.csrr),
    .i_ds_imm(ds.imm), .i_ds_pc(ds.pc), .i_ds_rd(ds.rd), .i_ds_csr(ds.csr),
    .i_ds_alu_src1_sel(ds.src1_sel), .i_ds_alu_src2_sel(ds.src2_sel),
    .i_ds_alu_word_cut_sel(ds.wcut), .i_ds_alu_op(ds.alu_op),
    .i_ds_gpr_wen(ds.gpr_wen), .i_ds_csr_wen(ds.csr_wen),
    .i_ds_mem_ren(ds.ren), .i_ds_mem_wen(ds.wen), .i_ds_mem_op(ds.mem_op),
    .i_ds_csr_inst_sel(ds.csr_inst), .i_ds_csr_op(ds.csr_op), .i_ds_load_sel(ds.load),
    .i_ms_allowin(ms_allowin), .o_es_to_ms_valid(es_to_ms_valid),
    .o_es_rd(es_rd), .o_es_csr(es_csr), .o_es_gpr_wen(es_gpr_wen),
    .o_es_csr_wen(es_csr_wen), .o_es_mem_ren(es_mem_ren), .o_es_mem_wen(es_mem_wen),
    .o_es_mem_op(es_mem_op), .o_es_csr_inst_sel(es_csr_inst_sel),
    .o_es_csrrdata(es_csrrdata), .o_es_alu_result(es_alu_result),
    .o_es_csr_result(es_csr_result),
    .o_load_sel(load_sel), .o_bypass_rd(byp_rd), .o_bypass_gpr_data(byp_gpr_data),
    .o_bypass_csr(byp_csr), .o_bypass_csr_data(byp_csr_data),
    .o_data_sram_req(sram_req), .o_data_sram_op(sram_op), .o_data_sram_size(sram_size),
    .o_data_sram_addr(sram_addr), .o_data_sram_wstrb(sram_wstrb),
    .o_data_sram_wdata(sram_wdata), .i_data_sram_addr_ok(addr_ok)
  );

  // taps x^16 x^14 x^13 x^11 with one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic exp_t ex_model(input instr_t t);
    logic [63:0] a, b, src;
    logic [31:0] r32;
    logic [15:0] m;
    logic [2:0]  low;
    exp_t e;
    a = t.src1_sel ? t.pc : t.rs1;
    b = (t.src2_sel == 2'd0) ? t.rs2 : (t.src2_sel == 2'd1) ? t.imm :
        (t.src2_sel == 2'd2) ? 64'd4 : 64'd0;
    if (t.wcut) begin
      case (t.alu_op)
        ALU_ADD: r32 = a[31:0] + b[31:0];
        ALU_SUB: r32 = a[31:0] - b[31:0];
        ALU_SLL: r32 = a[31:0] << b[4:0];
        ALU_SRL: r32 = a[31:0] >> b[4:0];
        default: r32 = $unsigned($signed(a[31:0]) >>> b[4:0]);
      endcase
      e.alu = {{32{r32[31]}}, r32};
    end else begin
      case (t.alu_op)
        ALU_ADD:   e.alu = a + b;
        ALU_SUB:   e.alu = a - b;
        ALU_SLL:   e.alu = a << b[5:0];
        ALU_SLT:   e.alu = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        ALU_SLTU:  e.alu = (a < b) ? 64'd1 : 64'd0;
        ALU_XOR:   e.alu = a ^ b;
        ALU_SRL:   e.alu = a >> b[5:0];
        ALU_SRA:   e.alu = $unsigned($signed(a) >>> b[5:0]);
        ALU_OR:    e.alu = a | b;
        ALU_AND:   e.alu = a & b;
        ALU_PASS2: e.alu = b;
        default:   e.alu = '0;
      endcase
    end
    src = (t.csr_op >= CSR_RWI) ? t.imm : t.rs1; // immediate forms
    if (t.csr_op == CSR_RW || t.csr_op == CSR_RWI) e.csr_res = src;
    else if (t.csr_op == CSR_RS || t.csr_op == CSR_RSI) e.csr_res = t.csrr | src;
    else if (t.csr_op == CSR_RC || t.csr_op == CSR_RCI) e.csr_res = t.csrr & ~src;
    else e.csr_res = '0;
    e.size  = t.mem_op[2:1];
    low     = e.alu[2:0];
    m       = ((16'd1 << (1 << e.size)) - 16'd1) << low;
    e.strb  = m[7:0];
    e.wdata = t.rs2 << (8 * low);
    return e;
  endfunction

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) stop_fail($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    instr_t t;
    exp_t   e;
    logic   have, req, go;
    if (rst_n) begin
      have = (in_q.size() > 0);
      t = have ? in_q[0] : '0;
      e = have ? exp_q[0] : '0;
      req = have && (t.wen || (t.ren && ms_allowin));
      go = have && (!(t.ren || t.wen) || (req && addr_ok));
      check_val("o_data_sram_req", sram_req, req);
      check_val("o_es_to_ms_valid", es_to_ms_valid, go);
      check_val("o_es_allowin", es_allowin, !have || (go && ms_allowin));
      check_val("o_load_sel", load_sel, have && t.load);
      check_val("o_bypass_rd", byp_rd, (have && !t.wen && t.gpr_wen) ? t.rd : '0);
      check_val("o_bypass_gpr_data", byp_gpr_data,
                (have && !t.wen && t.gpr_wen) ? e.alu : '0);
      check_val("o_bypass_csr", byp_csr, (have && !t.wen && t.csr_wen) ? t.csr : '0);
      check_val("o_bypass_csr_data", byp_csr_data,
                (have && !t.wen && t.csr_wen) ? e.csr_res : '0);
      if (req) begin
        check_val("o_data_sram_op", sram_op, t.wen);
        check_val("o_data_sram_size", sram_size, e.size);
        check_val("o_data_sram_addr", sram_addr, e.alu[31:0]);
        if (t.wen) begin
          check_val("o_data_sram_wstrb", sram_wstrb, e.strb);
          check_val("o_data_sram_wdata", sram_wdata, e.wdata);
        end
      end
      if (es_to_ms_valid && ms_allowin) begin
        check_val("o_es_alu_result", es_alu_result, e.alu);
        check_val("o_es_csr_result", es_csr_result, e.csr_res);
        check_val("o_es_csrrdata", es_csrrdata, t.csrr);
        check_val("o_es_rd", es_rd, t.rd);
        check_val("o_es_csr", es_csr, t.csr);
        check_val("o_es_gpr_wen", es_gpr_wen, t.gpr_wen);
        check_val("o_es_csr_wen", es_csr_wen, t.csr_wen);
        check_val("o_es_mem_ren", es_mem_ren, t.ren);
        check_val("o_es_mem_wen", es_mem_wen, t.wen);
        check_val("o_es_mem_op", es_mem_op, t.mem_op);
        check_val("o_es_csr_inst_sel", es_csr_inst_sel, t.csr_inst);
        void'(in_q.pop_front());
        void'(exp_q.pop_front());
      end
      if (ds_valid && es_allowin) begin
        in_q.push_back(ds);
        exp_q.push_back(ex_model(ds));
      end
    end
  end

  // memory side redrawn just after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    ms_allowin = (rand_bits(2) != 0);
    addr_ok    = 1'(rand_bits(1));
  endtask

  task automatic send(input instr_t t);
    int  waited;
    logic took;
    ds = t;
    ds_valid = 1'b1;
    waited = 0;
    forever begin
      @(negedge clk);
      took = es_allowin;
      next_cycle();
      if (took) break;
      waited++;
      if (waited > TIMEOUT) stop_fail("decode instruction never accepted");
    end
    ds_valid = 1'b0;
  endtask

  task automatic fill_random(output instr_t t);
    t = '0;
    t.rs1  = rand_bits(64);
    t.rs2  = rand_bits(64);
    t.csrr = rand_bits(64);
    t.imm  = rand_bits(64);
    t.pc   = rand_bits(64);
    t.rd   = GPR_ADDR_WD'(rand_bits(5));
    t.csr  = CSR_ADDR_WD'(rand_bits(12));
  endtask

  task automatic alu_instr(input logic [4:0] op, input logic s1, input logic [1:0] s2,
                           input logic wc, output instr_t t);
    fill_random(t);
    t.alu_op   = op;
    t.src1_sel = s1;
    t.src2_sel = s2;
    t.wcut     = wc;
    t.gpr_wen  = 1'b1;
  endtask

  task automatic csr_instr(input logic [2:0] op, output instr_t t);
    fill_random(t);
    if (op >= CSR_RWI) t.imm = {59'b0, t.imm[4:0]}; // zimm
    t.csr_op   = op;
    t.csr_wen  = 1'b1;
    t.gpr_wen  = 1'b1;
    t.csr_inst = 1'b1;
  endtask

  task automatic mem_instr(input logic st, input logic [2:0] mop, input logic [2:0] low,
                           output instr_t t);
    fill_random(t);
    t.rs1      = {t.rs1[63:3], 3'b000};
    t.imm      = {61'b0, low};
    t.src2_sel = SRC2_IMM;
    t.mem_op   = mop;
    t.wen      = st;
    t.ren      = !st;
    t.load     = !st;
    t.gpr_wen  = st ? 1'(rand_bits(1)) : 1'b1; // a store never bypasses
  endtask

  initial begin
    instr_t t;
    logic [4:0] op;
    int waited;
    ds_valid = 1'b0;
    ds = '0;
    ms_allowin = 1'b1;
    addr_ok = 1'b0;
    waited = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      if (++waited > TIMEOUT) stop_fail("reset never released");
    end
    @(negedge clk);
    check_val("o_es_to_ms_valid", es_to_ms_valid, 0);
    check_val("o_data_sram_req", sram_req, 0);
    check_val("o_load_sel", load_sel, 0);
    check_val("o_bypass_rd", byp_rd, 0);
    check_val("o_bypass_gpr_data", byp_gpr_data, 0);
    check_val("o_bypass_csr", byp_csr, 0);
    check_val("o_bypass_csr_data", byp_csr_data, 0);
    check_val("o_es_allowin", es_allowin, 1);
    next_cycle();
    for (int o = 0; o <= 11; o++)
      for (int s1 = 0; s1 < 2; s1++)
        for (int s2 = 0; s2 < 3; s2++) begin
          alu_instr(5'(o), 1'(s1), 2'(s2), 1'b0, t);
          send(t);
        end
    for (int o = 0; o < 5; o++) begin
      op = (o == 0) ? ALU_ADD : (o == 1) ? ALU_SUB : (o == 2) ? ALU_SLL :
           (o == 3) ? ALU_SRL : ALU_SRA;
      alu_instr(op, 1'b0, 2'(o % 2), 1'b1, t);
      send(t);
    end
    for (int c = 1; c <= 6; c++) begin
      csr_instr(3'(c), t);
      send(t);
    end
    for (int m = 0; m < 4; m++)
      for (int a = 0; a < 8; a++) begin
        mem_instr(1'b1, 3'(2 * m), 3'(a), t);
        send(t);
      end
    for (int m = 0; m < 7; m++) begin
      mem_instr(1'b0, 3'(m), 3'(rand_bits(3)), t);
      send(t);
    end
    // random mix under back-pressure
    for (int n = 0; n < 300; n++) begin
      case (rand_bits(2))
        0: begin
          op = 5'(rand_bits(4));
          if (op > 10) op = op - 5'd5;
          alu_instr(op, 1'(rand_bits(1)), 2'(rand_bits(1)), 1'b0, t);
          if (op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA})
            t.wcut = 1'(rand_bits(1));
        end
        1: csr_instr(3'(1 + (rand_bits(3) % 6)), t);
        2: mem_instr(1'b1, {2'(rand_bits(2)), 1'b0}, 3'(rand_bits(3)), t);
        default: mem_instr(1'b0, 3'(rand_bits(3) % 7), 3'(rand_bits(3)), t);
      endcase
      send(t);
      if (rand_bits(2) == 0) next_cycle();
    end
    waited = 0;
    while (in_q.size() > 0) begin
      next_cycle();
      if (++waited > TIMEOUT) stop_fail("pipeline did not drain");
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
